// File: bench/loader_trace.txt
# S speed model maxgap | A start | B/P index offset data | W addr data region | D bios xtide
# all values hex, speed 0 slow 1 mid 2 fast, model 0 pcxt 1 tandy, region 0 bios 1 xtide
S 0 0 3
A
B 00 0000000 ea
W f0000 ea 0
B 00 000fff0 5b
W ffff0 5b 0
B 03 0000010 11
B 00 0010123 c3
W ec123 c3 1
B 01 0010005 77
B 01 000abcd 42
W fabcd 42 0
B 02 0012345 9e
W ee345 9e 1
D 3 2
S 1 1 0
A
B 00 0000100 01
W f0100 01 0
B 00 0000101 02
W f0101 02 0
B 02 0000003 03
W ec003 03 1
B 04 0000000 ff
B 00 0000102 04
W f0102 04 0
B 00 1000000 05
B 02 1ffffff 06
W effff 06 1
D 6 4
S 2 1 1
P 00 0000200 aa
W f0200 aa 0
A
B 00 001ffff 10
W effff 10 1
B 01 0000000 20
W f0000 20 0
D 8 5
R
S 0 0 0
A
B 02 0000000 33
W ec000 33 1
B 00 0001234 44
W f1234 44 0
B 00 0001235 45
W f1235 45 0
D 2 1

// File: vlog.f
+incdir+source
source/loader_pkg.sv
source/bus_pkg.sv
source/reg_slice.sv
source/loader_decode.sv
source/cpu_tick_gen.sv
source/loader_write_seq.sv
source/reset_sequencer.sv
source/load_status.sv
source/pcxt_loader_top.sv
bench/tb_pcxt_loader.sv

// File: bench/tb_pcxt_loader.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcxt_macros.svh"

module tb_pcxt_loader
	import loader_pkg::*;
	import bus_pkg::*;
();

	localparam int GAP_MAX    = 3;
	localparam int PEND_WAIT  = 60;
	localparam int RST_CYCLES = 8;

	logic                   clk_chipset;
	logic                   reset_wire;
	logic                   dl_valid_i;
	dl_byte_t               dl_byte_i;
	logic                   dl_ready_o;
	logic                   dl_active_i;
	speed_t                 speed_i;
	model_t                 model_sel_i;
	logic                   mem_we_n_o;
	mem_write_t             mem_write_o;
	logic                   bus_request_o;
	logic                   cpu_reset_o;
	model_t                 model_o;
	logic                   led_o;
	logic [`PCXT_CNT_W-1:0] bios_count_o;
	logic [`PCXT_CNT_W-1:0] xtide_count_o;

	// expected writes from the trace, captured writes from the bus
	mem_write_t exp_q[$];
	mem_write_t got_q[$];
	mem_write_t exp_w;
	model_t     reset_model;
	int         cur_div = `PCXT_DIV_SLOW;
	int         cycle_cnt = 0;
	int         cycle_limit = 100000;
	int         low_cycles = 0;
	logic       we_n_prev = 1'b1;
	logic       bp_seen = 1'b0;

	pcxt_loader_top i_dut (
		.clk_chipset   (clk_chipset),
		.reset_wire    (reset_wire),
		.dl_valid_i    (dl_valid_i),
		.dl_byte_i     (dl_byte_i),
		.dl_ready_o    (dl_ready_o),
		.dl_active_i   (dl_active_i),
		.speed_i       (speed_i),
		.model_sel_i   (model_sel_i),
		.mem_we_n_o    (mem_we_n_o),
		.mem_write_o   (mem_write_o),
		.bus_request_o (bus_request_o),
		.cpu_reset_o   (cpu_reset_o),
		.model_o       (model_o),
		.led_o         (led_o),
		.bios_count_o  (bios_count_o),
		.xtide_count_o (xtide_count_o)
	);

	// 10 ns chipset clock
	initial begin
		clk_chipset = 1'b0;
		forever begin
			#5 clk_chipset = ~clk_chipset;
		end
	end

	//////////////////////////////////////////////////
	// error reporting and compares
	//////////////////////////////////////////////////

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Some tests failed");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_write(input string name, input mem_write_t exp_m, input mem_write_t got_m);
		if (got_m !== exp_m) begin
			abort_run($sformatf("ERR %0t %s expected %h/%h/%0d got %h/%h/%0d", $time, name,
				exp_m.addr, exp_m.data, exp_m.region, got_m.addr, got_m.data, got_m.region));
		end
	endtask

	task automatic check_model(input string name, input model_t exp_m, input model_t got_m);
		if (got_m !== exp_m) begin
			abort_run($sformatf("ERR %0t %s expected %0d got %0d", $time, name, exp_m, got_m));
		end
	endtask

	task automatic check_count(input string name, input logic [`PCXT_CNT_W-1:0] exp_c,
		input logic [`PCXT_CNT_W-1:0] got_c);
		if (got_c !== exp_c) begin
			abort_run($sformatf("ERR %0t %s expected %0d got %0d", $time, name, exp_c, got_c));
		end
	endtask

	task automatic check_bit(input string name, input logic exp_b, input logic got_b);
		if (got_b !== exp_b) begin
			abort_run($sformatf("ERR %0t %s expected %b got %b", $time, name, exp_b, got_b));
		end
	endtask

	// clk_chipset cycles per cpu tick
	function automatic int div_for(input speed_t s);
		case (s)
			SPEED_FAST: return `PCXT_DIV_FAST;
			SPEED_MID:  return `PCXT_DIV_MID;
			default:    return `PCXT_DIV_SLOW;
		endcase
	endfunction

	//////////////////////////////////////////////////
	// bus monitor and run limit
	//////////////////////////////////////////////////

	// strobe sampled on the falling edge, away from the register updates
	always @(negedge clk_chipset) begin
		if (!mem_we_n_o) begin
			if (we_n_prev) begin
				got_q.push_back(mem_write_o);
				if (exp_q.size() == 0) begin
					abort_run($sformatf("write to %h seen with no expected write left",
						mem_write_o.addr));
				end else begin
					exp_w = exp_q.pop_front();
					check_write("mem_write_o", exp_w, mem_write_o);
				end
			end else begin
				// address and data hold for the whole strobe
				check_write("mem_write_o", got_q[got_q.size()-1], mem_write_o);
			end
			low_cycles = low_cycles + 1;
		end else if (!we_n_prev) begin
			if (low_cycles < (`PCXT_WRITE_HOLD - 1) * cur_div + 1 ||
				low_cycles > `PCXT_WRITE_HOLD * cur_div) begin
				abort_run($sformatf("write strobe low for %0d cycles at divisor %0d, out of range",
					low_cycles, cur_div));
			end
			low_cycles = 0;
		end
		we_n_prev = mem_we_n_o;
	end

	always @(posedge clk_chipset) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit) begin
			abort_run($sformatf("run timed out after %0d clock cycles", cycle_limit));
		end
	end

	// limit from the trace length, worst case slow speed
	task automatic size_timeout();
		int               fd;
		int               rc;
		int               n_byte;
		int               n_ctrl;
		int               n_pend;
		logic [63:0]      tok;
		logic [8*128-1:0] rest;
		n_byte = 0;
		n_ctrl = 0;
		n_pend = 0;
		fd = $fopen("bench/loader_trace.txt", "r");
		if (fd == 0) begin
			abort_run("cannot open trace file bench/loader_trace.txt");
		end else begin
			while ($fscanf(fd, "%s", tok) == 1) begin
				if (tok == "B") begin
					n_byte = n_byte + 1;
				end else if (tok == "P") begin
					n_byte = n_byte + 1;
					n_pend = n_pend + 1;
				end else if (tok == "D" || tok == "R") begin
					n_ctrl = n_ctrl + 1;
				end
				rc = $fgets(rest, fd);
			end
			$fclose(fd);
			cycle_limit = n_byte * (`PCXT_WRITE_HOLD * `PCXT_DIV_SLOW + 4 + GAP_MAX) +
				n_ctrl * (`PCXT_CPU_RESET_HOLD + 1 + 16) + n_pend * PEND_WAIT + 400;
		end
	endtask

	//////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////

	// count posedges until the cpu leaves reset
	task automatic wait_release();
		int n;
		n = 0;
		do begin
			@(negedge clk_chipset);
			n++;
			// led follows the idle download one cycle late
			if (n == 1) begin
				check_bit("led_o", 1'b1, led_o);
			end
		end while (cpu_reset_o && n <= `PCXT_CPU_RESET_HOLD + 8);
		if (n != `PCXT_CPU_RESET_HOLD + 1) begin
			abort_run($sformatf("ERR %0t cpu_reset_o release after %0d cycles, expected %0d",
				$time, n, `PCXT_CPU_RESET_HOLD + 1));
		end
	endtask

	task automatic apply_reset();
		@(negedge clk_chipset);
		reset_wire  = 1'b1;
		dl_valid_i  = 1'b0;
		dl_active_i = 1'b0;
		reset_model = model_sel_i;
		repeat (RST_CYCLES - 1) @(negedge clk_chipset);
		check_bit("dl_ready_o", 1'b0, dl_ready_o);
		check_bit("mem_we_n_o", 1'b1, mem_we_n_o);
		check_bit("cpu_reset_o", 1'b1, cpu_reset_o);
		@(negedge clk_chipset);
		reset_wire = 1'b0;
		wait_release();
		check_model("model_o", reset_model, model_o);
		check_count("bios_count_o", '0, bios_count_o);
		check_count("xtide_count_o", '0, xtide_count_o);
	endtask

	// random idle gap, then hold valid until the byte is taken
	task automatic send_byte(input dl_byte_t b, input int gap_max);
		int gap;
		gap = (gap_max == 0) ? 0 : int'($urandom % (gap_max + 1));
		repeat (gap) begin
			@(negedge clk_chipset);
			dl_valid_i = 1'b0;
		end
		@(negedge clk_chipset);
		dl_valid_i = 1'b1;
		dl_byte_i  = b;
		// ready does not depend on valid, safe to read here
		while (!dl_ready_o) begin
			if (!mem_we_n_o) begin
				bp_seen = 1'b1;
			end
			@(negedge clk_chipset);
		end
		@(posedge clk_chipset);
	endtask

	// byte given while the cpu runs must wait for the next download
	task automatic hold_pending();
		int seen;
		seen = got_q.size();
		@(negedge clk_chipset);
		dl_valid_i = 1'b0;
		repeat (PEND_WAIT) @(negedge clk_chipset);
		check_bit("cpu_reset_o", 1'b0, cpu_reset_o);
		if (got_q.size() != seen || !mem_we_n_o) begin
			abort_run("byte offered after cpu release was written outside a download");
		end
	endtask

	task automatic finish_download(input logic [`PCXT_CNT_W-1:0] exp_bios,
		input logic [`PCXT_CNT_W-1:0] exp_xtide);
		@(negedge clk_chipset);
		dl_valid_i = 1'b0;
		// drain every expected write
		while (exp_q.size() != 0 || !mem_we_n_o) begin
			@(negedge clk_chipset);
		end
		repeat (2) @(negedge clk_chipset);
		check_bit("led_o", 1'b0, led_o);
		check_bit("bus_request_o", 1'b1, bus_request_o);
		check_count("bios_count_o", exp_bios, bios_count_o);
		check_count("xtide_count_o", exp_xtide, xtide_count_o);
		check_model("model_o", reset_model, model_o);
		dl_active_i = 1'b0;
		// bus request drops at once, led stays off until the next edge
		#1;
		check_bit("led_o", 1'b0, led_o);
		check_bit("bus_request_o", 1'b0, bus_request_o);
		wait_release();
	endtask

	initial begin : run_trace
		int               fd;
		int               rc;
		int               gap_max;
		logic [63:0]      tok;
		logic [8*128-1:0] rest;
		logic [31:0]      f1;
		logic [31:0]      f2;
		logic [31:0]      f3;
		dl_byte_t         b;
		mem_write_t       w;
		// seed the generator once
		rc          = $urandom(32'hec8d3d20);
		reset_wire  = 1'b1;
		dl_valid_i  = 1'b0;
		dl_byte_i   = '0;
		dl_active_i = 1'b0;
		speed_i     = SPEED_SLOW;
		model_sel_i = MODEL_PCXT;
		gap_max     = 0;
		size_timeout();
		apply_reset();
		fd = $fopen("bench/loader_trace.txt", "r");
		if (fd == 0) begin
			abort_run("cannot open trace file bench/loader_trace.txt");
		end else begin
			while ($fscanf(fd, "%s", tok) == 1) begin
				if (tok == "#") begin
					rc = $fgets(rest, fd);
				end else if (tok == "S") begin
					rc = $fscanf(fd, "%h %h %h", f1, f2, f3);
					@(negedge clk_chipset);
					check_model("model_o", reset_model, model_o);
					dl_valid_i  = 1'b0;
					speed_i     = speed_t'(f1[1:0]);
					model_sel_i = model_t'(f2[0]);
					cur_div     = div_for(speed_t'(f1[1:0]));
					gap_max     = (f3 > GAP_MAX) ? GAP_MAX : int'(f3);
				end else if (tok == "R") begin
					apply_reset();
				end else if (tok == "A") begin
					@(negedge clk_chipset);
					dl_valid_i  = 1'b0;
					dl_active_i = 1'b1;
				end else if (tok == "B" || tok == "P") begin
					rc = $fscanf(fd, "%h %h %h", f1, f2, f3);
					b.index  = f1[7:0];
					b.offset = f2[24:0];
					b.data   = f3[7:0];
					send_byte(b, gap_max);
					if (tok == "P") begin
						hold_pending();
					end
				end else if (tok == "W") begin
					rc = $fscanf(fd, "%h %h %h", f1, f2, f3);
					w.addr   = f1[19:0];
					w.data   = f2[7:0];
					w.region = region_t'(f3[1:0]);
					exp_q.push_back(w);
				end else if (tok == "D") begin
					rc = $fscanf(fd, "%h %h", f1, f2);
					finish_download(f1[`PCXT_CNT_W-1:0], f2[`PCXT_CNT_W-1:0]);
				end else begin
					abort_run($sformatf("unknown record %s in trace file", tok));
				end
			end
			$fclose(fd);
			if (!bp_seen) begin
				abort_run("dl_ready_o never went low while a write was held");
			end else begin
				$display("All tests passed");
				$finish;
			end
		end
	end

endmodule

`default_nettype wire

// File: source/pcxt_loader_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcxt_macros.svh"

// boot image loading path
module pcxt_loader_top
	import loader_pkg::*;
	import bus_pkg::*;
(
	input  wire                    clk_chipset,
	input  wire                    reset_wire,
	input  wire                    dl_valid_i,
	input  dl_byte_t               dl_byte_i,
	output logic                   dl_ready_o,
	input  wire                    dl_active_i,
	input  speed_t                 speed_i,
	input  model_t                 model_sel_i,
	output logic                   mem_we_n_o,
	output mem_write_t             mem_write_o,
	output logic                   bus_request_o,
	output logic                   cpu_reset_o,
	output model_t                 model_o,
	output logic                   led_o,
	output logic [`PCXT_CNT_W-1:0] bios_count_o,
	output logic [`PCXT_CNT_W-1:0] xtide_count_o
);

	logic       byte_valid;
	dl_byte_t   byte_q;
	logic       byte_ready;
	logic       req_valid;
	mem_write_t req;
	logic       req_ready;
	logic       cpu_tick;
	logic       cpu_reset;
	logic       done;
	region_t    done_region;

	// chipset bus owned by the loader for the whole download
	assign bus_request_o = dl_active_i;

	//////////////////////////////////////////////////
	// download port to decode
	//////////////////////////////////////////////////

	reg_slice #(
		.payload_t (dl_byte_t)
	) i_dl_slice (
		.clk_chipset (clk_chipset),
		.reset_wire  (reset_wire),
		.in_valid_i  (dl_valid_i),
		.in_data_i   (dl_byte_i),
		.in_ready_o  (dl_ready_o),
		.out_valid_o (byte_valid),
		.out_data_o  (byte_q),
		.out_ready_i (byte_ready)
	);

	loader_decode i_decode (
		.clk_chipset  (clk_chipset),
		.reset_wire   (reset_wire),
		.byte_valid_i (byte_valid),
		.byte_i       (byte_q),
		.byte_ready_o (byte_ready),
		.req_valid_o  (req_valid),
		.req_o        (req),
		.req_ready_i  (req_ready)
	);

	//////////////////////////////////////////////////
	// write execution
	//////////////////////////////////////////////////

	cpu_tick_gen i_tick (
		.clk_chipset (clk_chipset),
		.reset_wire  (reset_wire),
		.speed_i     (speed_i),
		.cpu_tick_o  (cpu_tick)
	);

	reset_sequencer i_rst_seq (
		.clk_chipset (clk_chipset),
		.reset_wire  (reset_wire),
		.dl_active_i (dl_active_i),
		.model_sel_i (model_sel_i),
		.cpu_reset_o (cpu_reset),
		.model_o     (model_o)
	);

	loader_write_seq i_write_seq (
		.clk_chipset   (clk_chipset),
		.reset_wire    (reset_wire),
		.req_valid_i   (req_valid),
		.req_i         (req),
		.req_ready_o   (req_ready),
		.cpu_tick_i    (cpu_tick),
		.cpu_reset_i   (cpu_reset),
		.mem_we_n_o    (mem_we_n_o),
		.mem_write_o   (mem_write_o),
		.done_o        (done),
		.done_region_o (done_region)
	);

	assign cpu_reset_o = cpu_reset;

	// result counters and led
	load_status i_status (
		.clk_chipset   (clk_chipset),
		.reset_wire    (reset_wire),
		.dl_active_i   (dl_active_i),
		.done_i        (done),
		.done_region_i (done_region),
		.led_o         (led_o),
		.bios_count_o  (bios_count_o),
		.xtide_count_o (xtide_count_o)
	);

endmodule

`default_nettype wire

// File: source/load_status.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcxt_macros.svh"

// completed write counters per region and download led
module load_status
	import loader_pkg::*;
(
	input  wire                   clk_chipset,
	input  wire                   reset_wire,
	input  wire                   dl_active_i,
	input  wire                   done_i,
	input  region_t               done_region_i,
	output logic                  led_o,
	output logic [`PCXT_CNT_W-1:0] bios_count_o,
	output logic [`PCXT_CNT_W-1:0] xtide_count_o
);

	logic [`PCXT_CNT_W-1:0] bios_cnt_q;
	logic [`PCXT_CNT_W-1:0] xtide_cnt_q;
	logic                   led_q;

	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			bios_cnt_q  <= '0;
			xtide_cnt_q <= '0;
			led_q       <= 1'b1;
		end else begin
			// led off while a download runs
			led_q <= ~dl_active_i;
			// saturate at all ones
			if (done_i && done_region_i == REGION_BIOS && ~&bios_cnt_q) begin
				bios_cnt_q <= bios_cnt_q + 1'b1;
			end
			if (done_i && done_region_i == REGION_XTIDE && ~&xtide_cnt_q) begin
				xtide_cnt_q <= xtide_cnt_q + 1'b1;
			end
		end
	end

	assign led_o         = led_q;
	assign bios_count_o  = bios_cnt_q;
	assign xtide_count_o = xtide_cnt_q;

endmodule

`default_nettype wire

// File: source/reset_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcxt_macros.svh"

// cpu reset hold and release, model latch
module reset_sequencer
	import bus_pkg::*;
(
	input  wire    clk_chipset,
	input  wire    reset_wire,
	input  wire    dl_active_i,
	input  model_t model_sel_i,
	output logic   cpu_reset_o,
	output model_t model_o
);

	localparam int CNT_W = $clog2(`PCXT_CPU_RESET_HOLD + 1);

	logic [CNT_W-1:0] release_cnt_q;
	logic             hold_q;
	model_t           model_q;

	//////////////////////////////////////////////////
	// release counter
	//////////////////////////////////////////////////

	// counter only runs once reset and download are both idle
	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			hold_q        <= 1'b1;
			release_cnt_q <= '0;
		end else if (dl_active_i) begin
			// download restarts the hold
			hold_q        <= 1'b1;
			release_cnt_q <= '0;
		end else if (hold_q) begin
			if (release_cnt_q == CNT_W'(`PCXT_CPU_RESET_HOLD)) begin
				hold_q <= 1'b0;
			end else begin
				release_cnt_q <= release_cnt_q + 1'b1;
			end
		end
	end

	// cpu also held for the whole download
	assign cpu_reset_o = hold_q | dl_active_i;

	// model follows the setting only while reset is asserted
	// a new model therefore needs a reset
	always_ff @(posedge clk_chipset) begin
		if (reset_wire) begin
			model_q <= model_sel_i;
		end
	end

	assign model_o = model_q;

endmodule

`default_nettype wire

// File: source/loader_write_seq.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcxt_macros.svh"

// memory write sequencer, strobe held for a number of cpu ticks
module loader_write_seq
	import loader_pkg::*;
	import bus_pkg::*;
(
	input  wire        clk_chipset,
	input  wire        reset_wire,
	input  wire        req_valid_i,
	input  mem_write_t req_i,
	output logic       req_ready_o,
	input  wire        cpu_tick_i,
	input  wire        cpu_reset_i,
	output logic       mem_we_n_o,
	output mem_write_t mem_write_o,
	output logic       done_o,
	output region_t    done_region_o
);

	localparam int TICK_W = $clog2(`PCXT_WRITE_HOLD);

	typedef enum logic {
		ST_IDLE,
		ST_HOLD
	} state_t;

	state_t            state_q;
	logic [TICK_W-1:0] tick_cnt_q;
	logic              we_n_q;
	logic              done_q;
	mem_write_t        write_q;

	// bus only taken while the cpu sits in reset
	// one dead cycle after done before the next request
	assign req_ready_o = (state_q == ST_IDLE) & cpu_reset_i & ~done_q;

	//////////////////////////////////////////////////
	// idle / hold fsm
	//////////////////////////////////////////////////

	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			state_q    <= ST_IDLE;
			tick_cnt_q <= '0;
			we_n_q     <= 1'b1;
			done_q     <= 1'b0;
		end else begin
			done_q <= 1'b0;
			case (state_q)
				ST_IDLE: begin
					if (req_valid_i && req_ready_o) begin
						state_q    <= ST_HOLD;
						tick_cnt_q <= '0;
						we_n_q     <= 1'b0;
					end
				end
				ST_HOLD: begin
					// count ticks seen with the strobe low
					if (cpu_tick_i) begin
						if (tick_cnt_q == TICK_W'(`PCXT_WRITE_HOLD - 1)) begin
							state_q <= ST_IDLE;
							we_n_q  <= 1'b1;
							done_q  <= 1'b1;
						end else begin
							tick_cnt_q <= tick_cnt_q + 1'b1;
						end
					end
				end
				default: begin
					state_q <= ST_IDLE;
					we_n_q  <= 1'b1;
				end
			endcase
		end
	end

	// address and data stay put for the whole strobe
	always_ff @(posedge clk_chipset) begin
		if (req_valid_i && req_ready_o) begin
			write_q <= req_i;
		end
	end

	assign mem_we_n_o    = we_n_q;
	assign mem_write_o   = write_q;
	assign done_o        = done_q;
	assign done_region_o = write_q.region;

endmodule

`default_nettype wire

// File: source/cpu_tick_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcxt_macros.svh"

// cpu clock enable, one pulse per cpu clock period
module cpu_tick_gen
	import bus_pkg::*;
(
	input  wire    clk_chipset,
	input  wire    reset_wire,
	input  speed_t speed_i,
	output logic   cpu_tick_o
);

	localparam int CNT_W = $clog2(`PCXT_DIV_SLOW);

	logic [CNT_W-1:0] cnt_q;
	logic [CNT_W-1:0] cnt_last;
	speed_t           speed_q;
	logic             tick_q;

	// terminal count per speed
	always_comb begin
		case (speed_i)
			SPEED_FAST: cnt_last = CNT_W'(`PCXT_DIV_FAST - 1);
			SPEED_MID:  cnt_last = CNT_W'(`PCXT_DIV_MID - 1);
			default:    cnt_last = CNT_W'(`PCXT_DIV_SLOW - 1);
		endcase
	end

	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			cnt_q   <= '0;
			speed_q <= SPEED_SLOW;
			tick_q  <= 1'b0;
		end else begin
			speed_q <= speed_i;
			if (speed_i != speed_q) begin
				// new speed, start a fresh period
				cnt_q  <= '0;
				tick_q <= 1'b0;
			end else if (cnt_q == cnt_last) begin
				cnt_q  <= '0;
				tick_q <= 1'b1;
			end else begin
				cnt_q  <= cnt_q + 1'b1;
				tick_q <= 1'b0;
			end
		end
	end

	// stands in for the cpu clock falling edge
	assign cpu_tick_o = tick_q;

endmodule

`default_nettype wire

// File: source/loader_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcxt_macros.svh"

// download byte to memory write request
module loader_decode
	import loader_pkg::*;
	import bus_pkg::*;
(
	input  wire        clk_chipset,
	input  wire        reset_wire,
	input  wire        byte_valid_i,
	input  dl_byte_t   byte_i,
	output logic       byte_ready_o,
	output logic       req_valid_o,
	output mem_write_t req_o,
	input  wire        req_ready_i
);

	logic       bios_hit;
	logic       xtide_hit;
	logic       keep;
	logic       slice_ready;
	mem_write_t req_d;

	//////////////////////////////////////////////////
	// region classification
	//////////////////////////////////////////////////

	// images 0 and 1, first 64 KB
	assign bios_hit  = (byte_i.index < 8'd2) && (byte_i.offset[24:16] == 9'd0);
	// image 2, or second 64 KB of image 0
	assign xtide_hit = (byte_i.index == 8'd2) ||
		((byte_i.index == 8'd0) && (byte_i.offset[24:16] == 9'd1));
	assign keep = bios_hit | xtide_hit;

	always_comb begin
		req_d.data = byte_i.data;
		// bios wins where both match
		if (bios_hit) begin
			req_d.addr   = {`PCXT_BIOS_BASE, byte_i.offset[15:0]};
			req_d.region = REGION_BIOS;
		end else if (xtide_hit) begin
			req_d.addr   = {`PCXT_XTIDE_BASE, byte_i.offset[13:0]};
			req_d.region = REGION_XTIDE;
		end else begin
			req_d.addr   = '1;
			req_d.region = REGION_NONE;
		end
	end

	// dropped bytes are taken at once and never reach the slice
	assign byte_ready_o = keep ? slice_ready : 1'b1;

	reg_slice #(
		.payload_t (mem_write_t)
	) i_req_slice (
		.clk_chipset (clk_chipset),
		.reset_wire  (reset_wire),
		.in_valid_i  (byte_valid_i & keep),
		.in_data_i   (req_d),
		.in_ready_o  (slice_ready),
		.out_valid_o (req_valid_o),
		.out_data_o  (req_o),
		.out_ready_i (req_ready_i)
	);

endmodule

`default_nettype wire

// File: source/reg_slice.sv
`timescale 1ns/1ps
`default_nettype none

// single entry valid/ready register stage
module reg_slice #(
	parameter type payload_t = logic [7:0]
) (
	input  wire      clk_chipset,
	input  wire      reset_wire,
	input  wire      in_valid_i,
	input  payload_t in_data_i,
	output logic     in_ready_o,
	output logic     out_valid_o,
	output payload_t out_data_o,
	input  wire      out_ready_i
);

	logic     valid_q;
	// low during reset, keeps ready low until the first clean cycle
	logic     live_q;
	payload_t data_q;

	// accept when empty or when the held item leaves this cycle
	assign in_ready_o = live_q & (~valid_q | out_ready_i);

	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			valid_q <= 1'b0;
			live_q  <= 1'b0;
		end else begin
			live_q <= 1'b1;
			// slot is free or being freed, so it takes whatever is offered
			if (in_ready_o) begin
				valid_q <= in_valid_i;
			end
		end
	end

	// payload only
	always_ff @(posedge clk_chipset) begin
		if (in_valid_i && in_ready_o) begin
			data_q <= in_data_i;
		end
	end

	assign out_valid_o = valid_q;
	assign out_data_o  = data_q;

endmodule

`default_nettype wire

// File: source/bus_pkg.sv
`default_nettype none

`include "pcxt_macros.svh"

// types seen on the memory bus side of the loader
package bus_pkg;

	import loader_pkg::*;

	// one memory write, region kept for the status counters
	typedef struct packed {
		logic [`PCXT_ADDR_W-1:0] addr;
		logic [`PCXT_DATA_W-1:0] data;
		region_t                 region;
	} mem_write_t;

	// cpu speed setting
	// slow 4.77, mid 7.16, fast 14.318 MHz
	typedef enum logic [1:0] {
		SPEED_SLOW = 2'd0,
		SPEED_MID  = 2'd1,
		SPEED_FAST = 2'd2
	} speed_t;

	// machine model latched at reset
	typedef enum logic {
		MODEL_PCXT  = 1'b0,
		MODEL_TANDY = 1'b1
	} model_t;

endpackage

`default_nettype wire

// File: source/loader_pkg.sv
`default_nettype none

`include "pcxt_macros.svh"

// types seen on the download side of the loader
package loader_pkg;

	//////////////////////////////////////////////////
	// target region of a download byte
	//////////////////////////////////////////////////

	// none means the byte is dropped
	typedef enum logic [1:0] {
		REGION_BIOS  = 2'd0,
		REGION_XTIDE = 2'd1,
		REGION_NONE  = 2'd2
	} region_t;

	//////////////////////////////////////////////////
	// one byte from the download port
	//////////////////////////////////////////////////

	// index selects the image
	// offset is the byte position inside the image
	typedef struct packed {
		logic [`PCXT_INDEX_W-1:0] index;
		logic [`PCXT_OFS_W-1:0]   offset;
		logic [`PCXT_DATA_W-1:0]  data;
	} dl_byte_t;

endpackage

`default_nettype wire

// File: source/pcxt_macros.svh
`ifndef PCXT_MACROS_SVH
`define PCXT_MACROS_SVH

//////////////////////////////////////////////////
// widths
//////////////////////////////////////////////////

// memory bus address, 1 MB space
`define PCXT_ADDR_W 20
// download offset as delivered by the port
`define PCXT_OFS_W 25
// image index and data byte
`define PCXT_INDEX_W 8
`define PCXT_DATA_W 8
// completed write counters
`define PCXT_CNT_W 16

//////////////////////////////////////////////////
// region windows and timing
//////////////////////////////////////////////////

// main bios window at F0000
`define PCXT_BIOS_BASE 4'hF
// xtide option rom window at EC000
`define PCXT_XTIDE_BASE 6'b111011
// cpu ticks the write strobe stays low
`define PCXT_WRITE_HOLD 4
// cycles from reset/download end to cpu release
`define PCXT_CPU_RESET_HOLD 42
// clk_chipset cycles per cpu tick, 4.77 / 7.16 / 14.318 MHz
`define PCXT_DIV_SLOW 12
`define PCXT_DIV_MID 8
`define PCXT_DIV_FAST 4

`endif
